// ==== common/console_pkg.sv ====
package console_pkg;

  // screen geometry.
  localparam int COLS    = 80;
  localparam int ROWS    = 30;
  localparam int CELLS   = COLS * ROWS;
  localparam int CELL_AW = 12;
  localparam int ROW_W   = 5;
  localparam int COL_W   = 7;

  // address map.
  localparam logic [31:0] BUF_BASE = 32'h0000_0000;
  localparam logic [31:0] REG_BASE = 32'h0001_0000;

  // register offsets inside the register window.
  localparam logic [3:0] REG_CTRL   = 4'h0;
  localparam logic [3:0] REG_SCROLL = 4'h4;
  localparam logic [3:0] REG_CURSOR = 4'h8;
  localparam logic [3:0] REG_STATUS = 4'hC;

  typedef struct packed {
    logic        Cyc;
    logic        Stb;
    logic        We;
    logic [3:0]  Sel;
    logic [31:0] Adr;
    logic [31:0] Data;
  } bus_req_t;

  typedef struct packed {
    logic        Ack;
    logic        Err;
    logic [31:0] Data;
  } bus_rsp_t;

  // one cell on the scanout stream.
  typedef struct packed {
    logic [ROW_W-1:0] row;
    logic [COL_W-1:0] col;
    logic [7:0]       ch;
    logic [7:0]       attr;
    logic             cursor;
    logic             last;
  } cell_t;

  typedef struct packed {
    logic             enable;
    logic [ROW_W-1:0] scroll;
    logic [ROW_W-1:0] cur_row;
    logic [COL_W-1:0] cur_col;
  } ctrl_t;

endpackage

// ==== src/wb_decoder.sv ====
module wb_decoder (
  input  logic                  clk,
  input  logic                  arst_n_i,
  input  console_pkg::bus_req_t bus_req_i,
  output console_pkg::bus_rsp_t bus_rsp_o,
  output console_pkg::bus_req_t buf_req_o,
  input  console_pkg::bus_rsp_t buf_rsp_i,
  output console_pkg::bus_req_t reg_req_o,
  input  console_pkg::bus_rsp_t reg_rsp_i
);
  import console_pkg::*;

  logic access;
  logic hit_buf;
  logic hit_reg;
  logic err_q;

  assign access = bus_req_i.Cyc & bus_req_i.Stb;

  // word index has to land inside the cell array.
  assign hit_buf = (bus_req_i.Adr[31:16] == BUF_BASE[31:16]) &&
                   (bus_req_i.Adr[15:2] < 14'(CELLS));

  assign hit_reg = (bus_req_i.Adr[31:16] == REG_BASE[31:16]) &&
                   (bus_req_i.Adr[15:4] == '0);

  // strobe only reaches the selected slave.
  always_comb
  begin
    buf_req_o     = bus_req_i;
    buf_req_o.Stb = bus_req_i.Stb & hit_buf;
    reg_req_o     = bus_req_i;
    reg_req_o.Stb = bus_req_i.Stb & hit_reg;
  end

  // unmapped access answered here.
  always_ff @(posedge clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      err_q <= 1'b0;
    end
    else
    begin
      err_q <= access & ~hit_buf & ~hit_reg;
    end
  end

  // only one responder acks per cycle and idle ones drive zero.
  always_comb
  begin
    bus_rsp_o.Ack  = buf_rsp_i.Ack | reg_rsp_i.Ack | err_q;
    bus_rsp_o.Err  = buf_rsp_i.Err | reg_rsp_i.Err | err_q;
    bus_rsp_o.Data = buf_rsp_i.Data | reg_rsp_i.Data;
  end

endmodule

// ==== console/console_buffer.sv ====
module console_buffer (
  input  logic                            clk,
  input  logic                            arst_n_i,
  input  console_pkg::bus_req_t           bus_req_i,
  output console_pkg::bus_rsp_t           bus_rsp_o,
  input  logic                            scan_rd_i,
  input  logic [console_pkg::CELL_AW-1:0] scan_idx_i,
  output logic [31:0]                     scan_word_o
);
  import console_pkg::*;

  // one array per byte lane.
  logic [7:0]         lane_mem [4][CELLS];
  logic               bus_stb;
  logic [CELL_AW-1:0] bus_idx;
  logic               ack_q;
  logic [31:0]        rd_data_q;

  assign bus_stb = bus_req_i.Cyc & bus_req_i.Stb;
  assign bus_idx = bus_req_i.Adr[CELL_AW+1:2];

  always_ff @(posedge clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      ack_q <= 1'b0;
    end
    else
    begin
      ack_q <= bus_stb;
    end
  end

  // bus port returns the word as it was before the write.
  always_ff @(posedge clk)
  begin
    if (bus_stb)
    begin
      for (int lane = 0; lane < 4; lane++)
      begin
        if (bus_req_i.We && bus_req_i.Sel[lane])
        begin
          lane_mem[lane][bus_idx] <= bus_req_i.Data[8*lane +: 8];
        end
        rd_data_q[8*lane +: 8] <= lane_mem[lane][bus_idx];
      end
    end
  end

  // scanout read port.
  always_ff @(posedge clk)
  begin
    if (scan_rd_i)
    begin
      for (int lane = 0; lane < 4; lane++)
      begin
        scan_word_o[8*lane +: 8] <= lane_mem[lane][scan_idx_i];
      end
    end
  end

  always_comb
  begin
    bus_rsp_o.Ack  = ack_q;
    bus_rsp_o.Err  = 1'b0;
    bus_rsp_o.Data = ack_q ? rd_data_q : '0;
  end

endmodule

// ==== console/console_regs.sv ====
module console_regs (
  input  logic                  clk,
  input  logic                  arst_n_i,
  input  console_pkg::bus_req_t bus_req_i,
  output console_pkg::bus_rsp_t bus_rsp_o,
  output console_pkg::ctrl_t    ctrl_o,
  input  logic                  frame_done_i
);
  import console_pkg::*;

  logic             access;
  logic             wr;
  logic             scroll_ok;
  logic             cursor_ok;
  logic             enable_q;
  logic [ROW_W-1:0] scroll_q;
  logic [ROW_W-1:0] cur_row_q;
  logic [COL_W-1:0] cur_col_q;
  logic [15:0]      frames_q;
  logic             ack_q;
  logic [31:0]      rd_mux;
  logic [31:0]      rd_data_q;

  assign access = bus_req_i.Cyc & bus_req_i.Stb;
  assign wr     = access & bus_req_i.We;

  // out of range values leave the register alone.
  assign scroll_ok = bus_req_i.Data < 32'(ROWS);
  assign cursor_ok = (bus_req_i.Data[12:8] < ROW_W'(ROWS)) &&
                     (bus_req_i.Data[6:0] < COL_W'(COLS));

  always_comb
  begin
    case (bus_req_i.Adr[3:0])
      REG_CTRL:   rd_mux = {31'b0, enable_q};
      REG_SCROLL: rd_mux = {27'b0, scroll_q};
      REG_CURSOR: rd_mux = {19'b0, cur_row_q, 1'b0, cur_col_q};
      REG_STATUS: rd_mux = {16'b0, frames_q};
      default:    rd_mux = '0;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      ack_q     <= 1'b0;
      enable_q  <= 1'b0;
      scroll_q  <= '0;
      cur_row_q <= '0;
      cur_col_q <= '0;
      frames_q  <= '0;
    end
    else
    begin
      ack_q <= access;
      if (frame_done_i)
      begin
        frames_q <= frames_q + 16'd1;
      end
      // status is read only and falls to default.
      if (wr)
      begin
        case (bus_req_i.Adr[3:0])
          REG_CTRL:   enable_q <= bus_req_i.Data[0];
          REG_SCROLL: if (scroll_ok) scroll_q <= bus_req_i.Data[ROW_W-1:0];
          REG_CURSOR:
          begin
            if (cursor_ok)
            begin
              cur_row_q <= bus_req_i.Data[12:8];
              cur_col_q <= bus_req_i.Data[6:0];
            end
          end
          default: ;
        endcase
      end
    end
  end

  // writes answer with zero data.
  always_ff @(posedge clk)
  begin
    if (access)
    begin
      rd_data_q <= wr ? '0 : rd_mux;
    end
  end

  always_comb
  begin
    bus_rsp_o.Ack  = ack_q;
    bus_rsp_o.Err  = 1'b0;
    bus_rsp_o.Data = ack_q ? rd_data_q : '0;
  end

  always_comb
  begin
    ctrl_o.enable  = enable_q;
    ctrl_o.scroll  = scroll_q;
    ctrl_o.cur_row = cur_row_q;
    ctrl_o.cur_col = cur_col_q;
  end

endmodule

// ==== console/char_scanout.sv ====
module char_scanout (
  input  logic                            clk,
  input  logic                            arst_n_i,
  input  console_pkg::ctrl_t              ctrl_i,
  output logic                            rd_o,
  output logic [console_pkg::CELL_AW-1:0] idx_o,
  input  logic [31:0]                     word_i,
  output console_pkg::cell_t              cell_o,
  output logic                            cell_valid_o,
  input  logic                            cell_ready_i,
  output logic                            frame_done_o
);
  import console_pkg::*;

  typedef enum logic [1:0] {S_IDLE, S_READ, S_DRAIN} state_t;

  state_t             state_q;
  logic [ROW_W-1:0]   row_q;
  logic [COL_W-1:0]   col_q;
  logic [ROW_W-1:0]   src_row_q;
  logic [ROW_W-1:0]   cur_row_q;
  logic [COL_W-1:0]   cur_col_q;
  logic               row_end;
  logic               frame_end;
  logic               pend_q;
  logic [ROW_W-1:0]   meta_row_q;
  logic [COL_W-1:0]   meta_col_q;
  logic               meta_cursor_q;
  logic               meta_last_q;
  cell_t              new_cell;
  cell_t              fifo_mem [2];
  logic               wr_ptr_q;
  logic               rd_ptr_q;
  logic [1:0]         count_q;
  logic [1:0]         used;
  logic               pop;

  assign pop       = cell_valid_o & cell_ready_i;
  assign row_end   = col_q == COL_W'(COLS - 1);
  assign frame_end = row_end && (row_q == ROW_W'(ROWS - 1));

  // read in flight counts against the two slots.
  assign used = count_q + {1'b0, pend_q} - {1'b0, pop};
  assign rd_o = (state_q == S_READ) && (used < 2'd2);

  assign idx_o = CELL_AW'(src_row_q) * CELL_AW'(COLS) + CELL_AW'(col_q);

  always_ff @(posedge clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      state_q   <= S_IDLE;
      row_q     <= '0;
      col_q     <= '0;
      src_row_q <= '0;
      cur_row_q <= '0;
      cur_col_q <= '0;
    end
    else
    begin
      case (state_q)
        S_IDLE:
        begin
          // scroll and cursor held for the whole frame.
          if (ctrl_i.enable)
          begin
            state_q   <= S_READ;
            row_q     <= '0;
            col_q     <= '0;
            src_row_q <= ctrl_i.scroll;
            cur_row_q <= ctrl_i.cur_row;
            cur_col_q <= ctrl_i.cur_col;
          end
        end
        S_READ:
        begin
          if (rd_o)
          begin
            if (row_end)
            begin
              col_q     <= '0;
              row_q     <= row_q + 1'b1;
              src_row_q <= (src_row_q == ROW_W'(ROWS - 1)) ? '0 : src_row_q + 1'b1;
            end
            else
            begin
              col_q <= col_q + 1'b1;
            end
            if (frame_end)
            begin
              state_q <= S_DRAIN;
            end
          end
        end
        default:
        begin
          if (frame_done_o)
          begin
            state_q <= S_IDLE;
          end
        end
      endcase
    end
  end

  // position of the read pairs with the word a cycle later.
  always_ff @(posedge clk)
  begin
    if (rd_o)
    begin
      meta_row_q    <= row_q;
      meta_col_q    <= col_q;
      meta_cursor_q <= (row_q == cur_row_q) && (col_q == cur_col_q);
      meta_last_q   <= frame_end;
    end
  end

  always_comb
  begin
    new_cell.row    = meta_row_q;
    new_cell.col    = meta_col_q;
    new_cell.ch     = word_i[7:0];
    new_cell.attr   = word_i[15:8];
    new_cell.cursor = meta_cursor_q;
    new_cell.last   = meta_last_q;
  end

  always_ff @(posedge clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      pend_q   <= 1'b0;
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= '0;
    end
    else
    begin
      pend_q   <= rd_o;
      wr_ptr_q <= wr_ptr_q ^ pend_q;
      rd_ptr_q <= rd_ptr_q ^ pop;
      count_q  <= count_q + {1'b0, pend_q} - {1'b0, pop};
    end
  end

  always_ff @(posedge clk)
  begin
    if (pend_q)
    begin
      fifo_mem[wr_ptr_q] <= new_cell;
    end
  end

  assign cell_o       = fifo_mem[rd_ptr_q];
  assign cell_valid_o = count_q != 2'd0;
  assign frame_done_o = pop & cell_o.last;

endmodule

// ==== src/console_top.sv ====
module console_top (
  input  logic                  clk,
  input  logic                  arst_n_i,
  input  console_pkg::bus_req_t bus_req_i,
  output console_pkg::bus_rsp_t bus_rsp_o,
  output console_pkg::cell_t    cell_o,
  output logic                  cell_valid_o,
  input  logic                  cell_ready_i
);
  import console_pkg::*;

  bus_req_t           buf_req;
  bus_rsp_t           buf_rsp;
  bus_req_t           reg_req;
  bus_rsp_t           reg_rsp;
  ctrl_t              ctrl;
  logic               scan_rd;
  logic [CELL_AW-1:0] scan_idx;
  logic [31:0]        scan_word;
  logic               frame_done;

  wb_decoder u_decoder (
    .clk       (clk),
    .arst_n_i  (arst_n_i),
    .bus_req_i (bus_req_i),
    .bus_rsp_o (bus_rsp_o),
    .buf_req_o (buf_req),
    .buf_rsp_i (buf_rsp),
    .reg_req_o (reg_req),
    .reg_rsp_i (reg_rsp)
  );

  console_buffer u_buffer (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .bus_req_i   (buf_req),
    .bus_rsp_o   (buf_rsp),
    .scan_rd_i   (scan_rd),
    .scan_idx_i  (scan_idx),
    .scan_word_o (scan_word)
  );

  console_regs u_regs (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .bus_req_i    (reg_req),
    .bus_rsp_o    (reg_rsp),
    .ctrl_o       (ctrl),
    .frame_done_i (frame_done)
  );

  char_scanout u_scanout (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .ctrl_i       (ctrl),
    .rd_o         (scan_rd),
    .idx_o        (scan_idx),
    .word_i       (scan_word),
    .cell_o       (cell_o),
    .cell_valid_o (cell_valid_o),
    .cell_ready_i (cell_ready_i),
    .frame_done_o (frame_done)
  );

endmodule

// ==== verification/console_tb.sv ====
module console_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import console_pkg::*;

  localparam logic [31:0] SEED   = 32'h4cf5a25f;
  localparam int          N_RAND = 200;
  localparam int          N_B2B  = 200;
  localparam int          FRAMES = 4;
  localparam int          BUS_OPS = CELLS + 2 * N_RAND + N_B2B + 100;
  localparam int          CYCLE_LIMIT = 4 * (BUS_OPS + FRAMES * CELLS) + 1000;

  typedef struct packed {
    logic [31:0] tag;
    logic        chk;
    bus_rsp_t    rsp;
  } pending_t;

  logic        clk;
  logic        arst_n_i;
  bus_req_t    bus_req_i;
  bus_rsp_t    bus_rsp_o;
  cell_t       cell_o;
  logic        cell_valid_o;
  logic        cell_ready_i;

  logic [31:0] lfsr_q;
  logic [31:0] cycle_cnt = '0;
  logic        rand_ready;
  pending_t    exp_q [$];
  // model of the buffer words and the registers.
  logic [31:0] shadow_mem [CELLS];
  logic        en_m;
  int          scroll_m;
  int          crow_m;
  int          ccol_m;
  int          frames_seen;
  int          frames_allowed;
  int          pos;
  int          f_scroll;
  int          f_row;
  int          f_col;
  logic        hold_q;
  cell_t       held_cell;
  int          idx_list [N_RAND];

  console_top UUT (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .bus_req_i    (bus_req_i),
    .bus_rsp_o    (bus_rsp_o),
    .cell_o       (cell_o),
    .cell_valid_o (cell_valid_o),
    .cell_ready_i (cell_ready_i)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1, "stopped at first error");
  endtask

  // x^32 + x^22 + x^2 + x + 1.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic logic [31:0] cursor_word(input int row, input int col);
    return (32'(row) << 8) | 32'(col);
  endfunction

  // expected response from the address map also updates the model.
  function automatic bus_rsp_t model_access(input bus_req_t req);
    bus_rsp_t r;
    int       idx;
    r.Ack  = 1'b1;
    r.Err  = 1'b0;
    r.Data = '0;
    idx    = int'(req.Adr[15:2]);
    if (req.Adr[31:16] == 16'h0000 && idx < CELLS)
    begin
      r.Data = shadow_mem[idx];
      for (int l = 0; l < 4; l++)
      begin
        if (req.We && req.Sel[l])
        begin
          shadow_mem[idx][8*l +: 8] = req.Data[8*l +: 8];
        end
      end
    end
    else if (req.Adr[31:16] == 16'h0001 && req.Adr[15:4] == 12'h000)
    begin
      if (req.We)
      begin
        if (req.Adr[3:0] == REG_CTRL)
          en_m = req.Data[0];
        else if (req.Adr[3:0] == REG_SCROLL && req.Data < 32'(ROWS))
          scroll_m = int'(req.Data);
        else if (req.Adr[3:0] == REG_CURSOR && int'(req.Data[12:8]) < ROWS &&
                 int'(req.Data[6:0]) < COLS)
        begin
          crow_m = int'(req.Data[12:8]);
          ccol_m = int'(req.Data[6:0]);
        end
      end
      else if (req.Adr[3:0] == REG_CTRL)
        r.Data = {31'b0, en_m};
      else if (req.Adr[3:0] == REG_SCROLL)
        r.Data = 32'(scroll_m);
      else if (req.Adr[3:0] == REG_CURSOR)
        r.Data = cursor_word(crow_m, ccol_m);
      else if (req.Adr[3:0] == REG_STATUS)
        r.Data = {16'b0, 16'(frames_seen)};
    end
    else
    begin
      r.Err = 1'b1;
    end
    return r;
  endfunction

  function automatic cell_t exp_cell(input int p, input int scroll, input int crow,
                                     input int ccol);
    cell_t       c;
    int          row;
    int          col;
    logic [31:0] w;
    row      = p / COLS;
    col      = p % COLS;
    w        = shadow_mem[((row + scroll) % ROWS) * COLS + col];
    c.row    = ROW_W'(row);
    c.col    = COL_W'(col);
    c.ch     = w[7:0];
    c.attr   = w[15:8];
    c.cursor = (row == crow) && (col == ccol);
    c.last   = (p == CELLS - 1);
    return c;
  endfunction

  task automatic check_rsp(input bus_rsp_t got, input bus_rsp_t exp, input logic chk);
    if (!got.Ack)
      report_failure("no acknowledge one cycle after a bus request");
    else if (got.Err !== exp.Err)
      report_failure($sformatf("** Error bus_rsp_o.Err: got %h, expected %h",
                               got.Err, exp.Err));
    else if (chk && got.Data !== exp.Data)
      report_failure($sformatf("** Error bus_rsp_o.Data: got %h, expected %h",
                               got.Data, exp.Data));
  endtask

  task automatic check_cell(input cell_t got, input cell_t exp, input int p);
    if (got !== exp)
      report_failure($sformatf("** Error cell_o at position %0d: got %h, expected %h",
                               p, got, exp));
  endtask

  // one falling edge of stimulus.
  task automatic drive_cycle(input bus_req_t req);
    logic [31:0] r;
    pending_t    p;
    @(negedge clk);
    r            = rand_ready ? rand_bits(1) : 32'h1;
    cell_ready_i = r[0];
    bus_req_i    = req;
    if (req.Stb)
    begin
      p.tag = cycle_cnt;
      p.rsp = model_access(req);
      p.chk = !req.We || p.rsp.Err;
      exp_q.push_back(p);
    end
  endtask

  task automatic bus_access(input logic we, input logic [31:0] adr, input logic [3:0] sel,
                            input logic [31:0] data);
    bus_req_t req;
    req.Cyc  = 1'b1;
    req.Stb  = 1'b1;
    req.We   = we;
    req.Sel  = sel;
    req.Adr  = adr;
    req.Data = data;
    drive_cycle(req);
  endtask

  task automatic idle_cycle();
    drive_cycle('0);
  endtask

  task automatic run_frames(input int k, input logic rnd);
    int waited;
    rand_ready     = rnd;
    frames_allowed = frames_seen + k;
    bus_access(1'b1, {REG_BASE[31:4], REG_CTRL}, 4'hF, 32'h1);
    bus_access(1'b0, {REG_BASE[31:4], REG_CTRL}, 4'hF, '0);
    waited = 0;
    while (!(frames_seen == frames_allowed - 1 && pos > 0))
    begin
      idle_cycle();
      waited++;
      if (waited > 4 * CELLS * k + 200)
        report_failure("stream never reached the last requested frame");
    end
    // scanout finishes the current frame and then stays idle.
    bus_access(1'b1, {REG_BASE[31:4], REG_CTRL}, 4'hF, 32'h0);
    waited = 0;
    while (frames_seen < frames_allowed)
    begin
      idle_cycle();
      waited++;
      if (waited > 4 * CELLS + 200)
        report_failure("stream ended short of the expected number of cells");
    end
    repeat (20) idle_cycle();
    rand_ready = 1'b0;
  endtask

  always @(posedge clk)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= 32'(CYCLE_LIMIT))
      report_failure("simulation timed out");
  end

  // bus responses checked one cycle after the request.
  always @(negedge clk)
  begin
    pending_t p;
    if (exp_q.size() > 0 && exp_q[0].tag == cycle_cnt - 1)
    begin
      p = exp_q.pop_front();
      check_rsp(bus_rsp_o, p.rsp, p.chk);
    end
    else if (bus_rsp_o.Ack)
      report_failure("acknowledge seen without an outstanding bus request");
  end

  always @(posedge clk)
  begin
    if (arst_n_i)
    begin
      if (hold_q && !cell_valid_o)
        report_failure("cell_valid_o dropped before the cell was taken");
      else if (hold_q && cell_o !== held_cell)
        report_failure($sformatf("** Error cell_o: changed from %h to %h while stalled",
                                 held_cell, cell_o));
      else if (cell_valid_o && cell_ready_i)
      begin
        if (frames_seen >= frames_allowed)
          report_failure("stream delivered more cells than the requested frames");
        else
        begin
          if (pos == 0)
          begin
            f_scroll = scroll_m;
            f_row    = crow_m;
            f_col    = ccol_m;
          end
          check_cell(cell_o, exp_cell(pos, f_scroll, f_row, f_col), pos);
          if (pos == CELLS - 1)
          begin
            pos = 0;
            frames_seen++;
          end
          else
            pos++;
        end
      end
      hold_q    = cell_valid_o && !cell_ready_i;
      held_cell = cell_o;
    end
  end

  initial
  begin
    int          idx;
    logic [31:0] op;
    bus_req_i      = '0;
    cell_ready_i   = 1'b0;
    arst_n_i       = 1'b0;
    rand_ready     = 1'b0;
    lfsr_q         = SEED;
    en_m           = 1'b0;
    scroll_m       = 0;
    crow_m         = 0;
    ccol_m         = 0;
    frames_seen    = 0;
    frames_allowed = 0;
    pos            = 0;
    hold_q         = 1'b0;
    repeat (3) @(negedge clk);
    arst_n_i = 1'b1;
    if (bus_rsp_o.Ack || bus_rsp_o.Err || cell_valid_o)
      report_failure("outputs not idle after reset");

    // fill every cell back to back.
    for (int i = 0; i < CELLS; i++)
      bus_access(1'b1, 32'(i * 4), 4'hF, (32'(i) * 32'h9e37_79b1) ^ 32'h5a00_00c3);

    for (int i = 0; i < N_RAND; i++)
    begin
      idx_list[i] = int'(rand_bits(12)) % CELLS;
      bus_access(1'b1, 32'(idx_list[i] * 4), 4'(rand_bits(4)), rand_bits(32));
    end
    repeat (3) idle_cycle();
    for (int i = 0; i < N_RAND; i++)
      bus_access(1'b0, 32'(idx_list[i] * 4), 4'hF, '0);

    // mixed reads and writes on consecutive cycles.
    for (int i = 0; i < N_B2B; i++)
    begin
      op  = rand_bits(1);
      idx = int'(rand_bits(12)) % CELLS;
      bus_access(op[0], 32'(idx * 4), 4'(rand_bits(4)), rand_bits(32));
    end
    repeat (3) idle_cycle();

    bus_access(1'b1, {REG_BASE[31:4], REG_CTRL}, 4'hF, 32'hFFFF_FFFE);
    bus_access(1'b0, {REG_BASE[31:4], REG_CTRL}, 4'hF, '0);
    bus_access(1'b1, {REG_BASE[31:4], REG_SCROLL}, 4'hF, 32'd7);
    bus_access(1'b0, {REG_BASE[31:4], REG_SCROLL}, 4'hF, '0);
    bus_access(1'b1, {REG_BASE[31:4], REG_SCROLL}, 4'hF, 32'(ROWS));
    bus_access(1'b1, {REG_BASE[31:4], REG_SCROLL}, 4'hF, 32'h0001_0003);
    bus_access(1'b0, {REG_BASE[31:4], REG_SCROLL}, 4'hF, '0);
    bus_access(1'b1, {REG_BASE[31:4], REG_CURSOR}, 4'hF, cursor_word(12, 40));
    bus_access(1'b0, {REG_BASE[31:4], REG_CURSOR}, 4'hF, '0);
    bus_access(1'b1, {REG_BASE[31:4], REG_CURSOR}, 4'hF, cursor_word(ROWS, 3));
    bus_access(1'b1, {REG_BASE[31:4], REG_CURSOR}, 4'hF, cursor_word(2, COLS));
    bus_access(1'b0, {REG_BASE[31:4], REG_CURSOR}, 4'hF, '0);
    bus_access(1'b1, {REG_BASE[31:4], REG_STATUS}, 4'hF, 32'd1234);
    bus_access(1'b0, {REG_BASE[31:4], REG_STATUS}, 4'hF, '0);

    // unmapped addresses including aliases of buffer and register bits.
    for (int i = 0; i < 6; i++)
    begin
      op = (i == 0) ? 32'h0000_2580 : (i == 1) ? 32'h0000_FFFC :
           (i == 2) ? 32'h0001_0010 : (i == 3) ? 32'h8000_0004 :
           (i == 4) ? 32'h0004_0008 : 32'h0002_0004;
      bus_access(1'b1, op, 4'hF, 32'hDEAD_BEEF);
      bus_access(1'b0, op, 4'hF, '0);
    end
    bus_access(1'b0, 32'h0000_0004, 4'hF, '0);
    bus_access(1'b0, 32'h0000_0008, 4'hF, '0);
    bus_access(1'b0, {REG_BASE[31:4], REG_SCROLL}, 4'hF, '0);

    run_frames(2, 1'b0);
    bus_access(1'b0, {REG_BASE[31:4], REG_STATUS}, 4'hF, '0);
    bus_access(1'b1, {REG_BASE[31:4], REG_SCROLL}, 4'hF, 32'(ROWS - 1));
    bus_access(1'b1, {REG_BASE[31:4], REG_CURSOR}, 4'hF, cursor_word(ROWS - 1, COLS - 1));
    run_frames(FRAMES - 2, 1'b1);
    bus_access(1'b0, {REG_BASE[31:4], REG_STATUS}, 4'hF, '0);

    repeat (4) idle_cycle();
    if (exp_q.size() != 0)
      report_failure("bus responses still outstanding at the end of the run");
    else
    begin
      $display("Test OK");
      $finish;
    end
  end

endmodule

// ==== console_sys.f ====
common/console_pkg.sv
src/wb_decoder.sv
console/console_buffer.sv
console/console_regs.sv
console/char_scanout.sv
src/console_top.sv
verification/console_tb.sv

// ==== Makefile ====
BIN := obj_dir/Vconsole_tb
SRC := $(filter-out +%,$(shell cat console_sys.f))

.PHONY: all run clean

all: run

$(BIN): console_sys.f $(SRC)
	verilator --binary --timing -j 0 -Wno-fatal --timescale 1ns/1ps \
	  --top-module console_tb -f console_sys.f

run: $(BIN)
	./$(BIN) | tee sim.log
	@if grep -q "Test FAILED" sim.log; then \
	  echo "simulation reported a failure"; exit 1; \
	fi
	@grep -q "Test OK" sim.log || (echo "simulation ended without passing"; exit 1)

clean:
	rm -rf obj_dir sim.log
